// File: lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width of the load/store path
`define XLEN 32

// sram depth in 32-bit words
`define MEM_WORDS 1024

// word index width, log2 of MEM_WORDS
`define MEM_AW 10

// byte lanes per word
`define LSU_LANES (`XLEN / 8)

`endif

// File: lsu_pkg.sv
package lsu_pkg;

   // memory operation from decode
   // loads first, then stores
   typedef enum logic [2:0] {
      op_lb,
      op_lh,
      op_lw,
      op_lbu,
      op_lhu,
      op_sb,
      op_sh,
      op_sw
   } mem_op_e;

   // load/store unit sequencing
   // st_ar and st_r are only visited by aligned loads
   typedef enum logic [1:0] {
      st_idle,
      st_ar,
      st_r,
      st_done
   } lsu_state_e;

endpackage

// File: sram_slave.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module sram_slave (
   input  logic                    clk,
   input  logic                    rst,
   // read address channel
   input  logic [`XLEN-1:0]        araddr,
   input  logic                    arvalid,
   output logic                    arready,
   // read data channel
   input  logic                    rready,
   output logic                    rvalid,
   output logic [`XLEN-1:0]        rdata,
   // write port
   input  logic                    w_en,
   input  logic [`XLEN-1:0]        waddr,
   input  logic [`XLEN-1:0]        wdata,
   input  logic [`LSU_LANES-1:0]   wmask
);

   localparam int lanes = `LSU_LANES;

   logic [`XLEN-1:0]   mem [`MEM_WORDS];

   logic               ar_hs;
   logic               r_hs;
   logic               rd_pending;
   logic [`MEM_AW-1:0] rd_idx;
   logic [`MEM_AW-1:0] w_idx;

   assign ar_hs = arvalid && arready;
   assign r_hs  = rvalid && rready;

   // byte offset dropped, upper bits alias
   assign w_idx = waddr[`MEM_AW+1:2];

   // byte-masked write
   always_ff @(posedge clk) begin
      if (w_en) begin
         for (int i = 0; i < lanes; i++) begin
            if (wmask[i]) begin
               mem[w_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
   end

   // word index captured on the address handshake
   always_ff @(posedge clk) begin
      if (ar_hs) begin
         rd_idx <= araddr[`MEM_AW+1:2];
      end
   end

   // set between address handshake and rvalid rising
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_pending <= 1'b0;
      end else if (ar_hs) begin
         rd_pending <= 1'b1;
      end else begin
         rd_pending <= 1'b0;
      end
   end

   // one read in flight, so arready stays low from the handshake
   // until the data beat has been taken
   always_ff @(posedge clk) begin
      if (rst) begin
         arready <= 1'b0;
      end else if (ar_hs || rd_pending) begin
         arready <= 1'b0;
      end else if (rvalid && !rready) begin
         arready <= 1'b0;
      end else begin
         arready <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rvalid <= 1'b0;
      end else if (rd_pending) begin
         rvalid <= 1'b1;
      end else if (r_hs) begin
         rvalid <= 1'b0;
      end
   end

   // array read one edge after the handshake
   // so a write on the handshake edge is already in the array
   always_ff @(posedge clk) begin
      if (rd_pending) begin
         rdata <= mem[rd_idx];
      end
   end

   // data beat must hold under back-pressure
   a_rdata_hold: assert property (
      @(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata)
   ) else $error("sram_slave: rdata changed while waiting for rready");

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module load_store_unit
   import lsu_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   // request from decode
   input  logic                    req_valid,
   input  mem_op_e                 req_op,
   input  logic [`XLEN-1:0]        req_addr,
   input  logic [`XLEN-1:0]        req_wdata,
   output logic                    busy,
   output logic                    done,
   output logic                    fault,
   output logic [`XLEN-1:0]        load_data,
   // read address channel
   output logic [`XLEN-1:0]        araddr,
   output logic                    arvalid,
   input  logic                    arready,
   // read data channel
   input  logic                    rvalid,
   output logic                    rready,
   input  logic [`XLEN-1:0]        rdata,
   // write port
   output logic                    w_en,
   output logic [`XLEN-1:0]        waddr,
   output logic [`XLEN-1:0]        wdata,
   output logic [`LSU_LANES-1:0]   wmask
);

   lsu_state_e          state;
   lsu_state_e          state_nxt;

   mem_op_e             op_q;
   logic [`XLEN-1:0]    addr_q;
   logic [`XLEN-1:0]    wdata_q;
   logic                misalign_q;

   logic                accept;
   logic                req_store;
   logic                req_misalign;
   logic                store_q;
   logic [`XLEN-1:0]    word_addr;
   logic [7:0]          sel_byte;
   logic [15:0]         sel_half;
   logic [`XLEN-1:0]    ext_data;

   assign accept    = req_valid && !busy;
   assign req_store = req_op inside {op_sb, op_sh, op_sw};

   // halfwords on even addresses, words on multiples of four
   always_comb begin
      case (req_op)
         op_lh, op_lhu, op_sh: req_misalign = req_addr[0];
         op_lw, op_sw:         req_misalign = |req_addr[1:0];
         default:              req_misalign = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op_q    <= req_op;
         addr_q  <= req_addr;
         wdata_q <= req_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         misalign_q <= 1'b0;
      end else if (accept) begin
         misalign_q <= req_misalign;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // stores and faults finish one cycle after acceptance
   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (accept) begin
               if (req_store || req_misalign) begin
                  state_nxt = st_done;
               end else begin
                  state_nxt = st_ar;
               end
            end
         end
         st_ar: begin
            if (arready) begin
               state_nxt = st_r;
            end
         end
         st_r: begin
            if (rvalid) begin
               state_nxt = st_done;
            end
         end
         st_done: state_nxt = st_idle;
         default: state_nxt = st_idle;
      endcase
   end

   assign busy  = (state != st_idle);
   assign done  = (state == st_done);
   assign fault = done && misalign_q;

   assign store_q   = op_q inside {op_sb, op_sh, op_sw};
   assign word_addr = {addr_q[`XLEN-1:2], 2'b00};

   // read channels
   assign araddr  = word_addr;
   assign arvalid = (state == st_ar);
   assign rready  = (state == st_r);

   // no write strobe on a fault
   assign w_en  = done && store_q && !misalign_q;
   assign waddr = word_addr;

   // replicate the value so every lane carries it
   always_comb begin
      case (op_q)
         op_sb: begin
            wdata = {(`LSU_LANES){wdata_q[7:0]}};
            wmask = `LSU_LANES'(1) << addr_q[1:0];
         end
         op_sh: begin
            wdata = {(`LSU_LANES/2){wdata_q[15:0]}};
            wmask = addr_q[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            wdata = wdata_q;
            wmask = '1;
         end
      endcase
   end

   // lane select from the returned word
   assign sel_byte = rdata[{addr_q[1:0], 3'b000} +: 8];
   assign sel_half = rdata[{addr_q[1], 4'b0000} +: 16];

   always_comb begin
      case (op_q)
         op_lb:   ext_data = {{(`XLEN-8){sel_byte[7]}}, sel_byte};
         op_lbu:  ext_data = {{(`XLEN-8){1'b0}}, sel_byte};
         op_lh:   ext_data = {{(`XLEN-16){sel_half[15]}}, sel_half};
         op_lhu:  ext_data = {{(`XLEN-16){1'b0}}, sel_half};
         default: ext_data = rdata;
      endcase
   end

   // held until the next load completes
   always_ff @(posedge clk) begin
      if (rvalid && rready) begin
         load_data <= ext_data;
      end
   end

   a_no_req_busy: assert property (
      @(posedge clk) disable iff (rst)
      busy |-> !req_valid
   ) else $error("load_store_unit: request issued while busy");

   a_ar_hold: assert property (
      @(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr)
   ) else $error("load_store_unit: arvalid dropped before arready");

endmodule

// File: mem_subsystem_top.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module mem_subsystem_top
   import lsu_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               req_valid,
   input  mem_op_e            req_op,
   input  logic [`XLEN-1:0]   req_addr,
   input  logic [`XLEN-1:0]   req_wdata,
   output logic               busy,
   output logic               done,
   output logic               fault,
   output logic [`XLEN-1:0]   load_data
);

   // read channels
   logic [`XLEN-1:0]       araddr;
   logic                   arvalid;
   logic                   arready;
   logic                   rvalid;
   logic                   rready;
   logic [`XLEN-1:0]       rdata;

   // write port
   logic                   w_en;
   logic [`XLEN-1:0]       waddr;
   logic [`XLEN-1:0]       wdata;
   logic [`LSU_LANES-1:0]  wmask;

   load_store_unit u_lsu (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_op    (req_op),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .busy      (busy),
      .done      (done),
      .fault     (fault),
      .load_data (load_data),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rvalid    (rvalid),
      .rready    (rready),
      .rdata     (rdata),
      .w_en      (w_en),
      .waddr     (waddr),
      .wdata     (wdata),
      .wmask     (wmask)
   );

   sram_slave u_sram (
      .clk     (clk),
      .rst     (rst),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rready  (rready),
      .rvalid  (rvalid),
      .rdata   (rdata),
      .w_en    (w_en),
      .waddr   (waddr),
      .wdata   (wdata),
      .wmask   (wmask)
   );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int half_period = 5
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // high over the first two rising edges, released on a falling edge
   initial begin
      rst = 1'b1;
      repeat (2) @(negedge clk);
      rst = 1'b0;
   end

endmodule

// File: tb_mem_subsystem.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module tb_mem_subsystem
   import lsu_pkg::*;
;

   // about 300 operations at up to 12 cycles each
   localparam int max_cycles = 4000;
   localparam int fill_words = 32;

   logic               clk;
   logic               rst;
   logic               req_valid;
   mem_op_e            req_op;
   logic [`XLEN-1:0]   req_addr;
   logic [`XLEN-1:0]   req_wdata;
   logic               busy;
   logic               done;
   logic               fault;
   logic [`XLEN-1:0]   load_data;

   logic [`XLEN-1:0]   model_mem [`MEM_WORDS];
   integer             seed;
   int                 cycles;

   tb_clock_gen u_clk (
      .clk (clk),
      .rst (rst)
   );

   mem_subsystem_top uut (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_op    (req_op),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .busy      (busy),
      .done      (done),
      .fault     (fault),
      .load_data (load_data)
   );

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   function automatic logic is_misaligned(input mem_op_e op, input logic [31:0] addr);
      case (op)
         op_lh, op_lhu, op_sh: return addr[0];
         op_lw, op_sw:         return addr[1:0] != 2'b00;
         default:              return 1'b0;
      endcase
   endfunction

   function automatic logic is_store(input mem_op_e op);
      return (op == op_sb) || (op == op_sh) || (op == op_sw);
   endfunction

   // index drops the byte offset, higher bits alias
   function automatic int word_index(input logic [31:0] addr);
      return int'(addr[`MEM_AW+1:2]);
   endfunction

   task automatic model_store(input mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] data);
      logic [31:0] mask;
      logic [4:0]  shift;
      int          i;
      i = word_index(addr);
      shift = 5'd0;
      case (op)
         op_sb: begin
            shift = {addr[1:0], 3'b000};
            mask = 32'h0000_00ff << shift;
         end
         op_sh: begin
            shift = {addr[1], 4'b0000};
            mask = 32'h0000_ffff << shift;
         end
         default: mask = 32'hffff_ffff;
      endcase
      model_mem[i] = (model_mem[i] & ~mask) | ((data << shift) & mask);
   endtask

   function automatic logic [31:0] expected_load(input mem_op_e op, input logic [31:0] addr);
      logic [31:0] w;
      logic [7:0]  b;
      logic [15:0] h;
      w = model_mem[word_index(addr)];
      b = 8'(w >> {addr[1:0], 3'b000});
      h = 16'(w >> {addr[1], 4'b0000});
      case (op)
         op_lb:   return 32'($signed(b));
         op_lbu:  return {24'h0, b};
         op_lh:   return 32'($signed(h));
         op_lhu:  return {16'h0, h};
         default: return w;
      endcase
   endfunction

   // called on a falling edge, returns on the falling edge that shows done
   task automatic issue_request(input mem_op_e op, input logic [31:0] addr,
                                input logic [31:0] data);
      check("busy", 32'(busy), 32'h0);
      req_valid = 1'b1;
      req_op    = op;
      req_addr  = addr;
      req_wdata = data;
      @(negedge clk);
      req_valid = 1'b0;
      while (!done) begin
         @(negedge clk);
      end
      check("fault", 32'(fault), 32'(is_misaligned(op, addr)));
   endtask

   // done lasts one cycle and the unit is idle right after
   task automatic finish_request();
      @(negedge clk);
      check("done", 32'(done), 32'h0);
      check("busy", 32'(busy), 32'h0);
   endtask

   task automatic do_store(input mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] data);
      issue_request(op, addr, data);
      if (!is_misaligned(op, addr)) begin
         model_store(op, addr, data);
      end
      finish_request();
   endtask

   task automatic do_load(input mem_op_e op, input logic [31:0] addr);
      issue_request(op, addr, 32'h0);
      if (!is_misaligned(op, addr)) begin
         check("load_data", load_data, expected_load(op, addr));
      end
      finish_request();
   endtask

   task automatic idle_after_reset();
      repeat (5) begin
         @(negedge clk);
         check("busy", 32'(busy), 32'h0);
         check("done", 32'(done), 32'h0);
         check("fault", 32'(fault), 32'h0);
      end
   endtask

   // low words used by the mixed sequence
   task automatic fill_region();
      logic [31:0] a;
      for (int i = 0; i < fill_words; i++) begin
         a = 32'(i * 4);
         do_store(op_sw, a, {a[15:0], ~a[15:0]} ^ 32'h3c3c_a5a5);
      end
   endtask

   task automatic word_store_load();
      logic [31:0] addrs[$];
      logic [31:0] a;
      for (int i = 0; i < 16; i++) begin
         a = $random(seed) & 32'hffff_fffc;
         addrs.push_back(a);
         do_store(op_sw, a, $random(seed));
      end
      foreach (addrs[i]) begin
         do_load(op_lw, addrs[i]);
      end
   endtask

   task automatic sub_word_stores();
      do_store(op_sw, 32'h100, 32'h1122_3344);
      do_store(op_sb, 32'h101, 32'hffff_ffab);
      do_load(op_lw, 32'h100);
      do_store(op_sh, 32'h102, 32'h5555_cdef);
      do_load(op_lw, 32'h100);
      do_store(op_sb, 32'h103, 32'h0000_0077);
      do_load(op_lw, 32'h100);
      do_store(op_sh, 32'h100, 32'hdead_0a0b);
      do_load(op_lw, 32'h100);
      do_store(op_sb, 32'h100, 32'h0000_00e1);
      do_load(op_lw, 32'h100);
   endtask

   // bytes and halfwords with the top bit both set and clear
   task automatic load_extension();
      logic [31:0] base;
      do_store(op_sw, 32'h200, 32'h807f_f00f);
      do_store(op_sw, 32'h204, 32'h7ffe_8001);
      for (int w = 0; w < 2; w++) begin
         base = 32'h200 + 32'(w * 4);
         for (int off = 0; off < 4; off++) begin
            do_load(op_lb, base + 32'(off));
            do_load(op_lbu, base + 32'(off));
         end
         for (int off = 0; off < 4; off += 2) begin
            do_load(op_lh, base + 32'(off));
            do_load(op_lhu, base + 32'(off));
         end
         do_load(op_lw, base);
      end
   endtask

   task automatic misaligned_accesses();
      do_store(op_sw, 32'h300, 32'h0bad_f00d);
      do_load(op_lh, 32'h301);
      do_load(op_lhu, 32'h303);
      do_load(op_lw, 32'h301);
      do_load(op_lw, 32'h302);
      do_store(op_sh, 32'h301, 32'hffff_ffff);
      do_store(op_sh, 32'h303, 32'h1234_5678);
      do_store(op_sw, 32'h302, 32'hffff_ffff);
      do_store(op_sw, 32'h303, 32'h0000_0000);
      do_load(op_lw, 32'h300);
   endtask

   // address bits 11..7 kept clear so accesses land in the filled words
   task automatic mixed_random_ops();
      mem_op_e     op;
      logic [31:0] a;
      logic [31:0] r;
      for (int n = 0; n < 200; n++) begin
         r  = $random(seed);
         op = mem_op_e'(r[2:0]);
         a  = $random(seed) & 32'hffff_f07f;
         if (is_store(op)) begin
            do_store(op, a, $random(seed));
         end else begin
            do_load(op, a);
         end
      end
   endtask

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: done never arrived");
      $display("Testbench failed");
      $fatal(1);
   end

   initial begin
      req_valid = 1'b0;
      req_op    = op_lw;
      req_addr  = '0;
      req_wdata = '0;
      seed      = 70;
      @(negedge rst);
      idle_after_reset();
      fill_region();
      word_store_load();
      sub_word_stores();
      load_extension();
      misaligned_accesses();
      mixed_random_ops();
      $display("Testbench passed");
      $finish;
   end

endmodule

// File: sources.f
+incdir+.
lsu_pkg.sv
sram_slave.sv
load_store_unit.sv
mem_subsystem_top.sv
tb_clock_gen.sv
tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_mem_subsystem -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Testbench passed" \
   && echo "run.sh: simulation ok" && exit 0 \
   || { echo "run.sh: simulation not ok"; exit 1; }
